//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = gsu_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/gsu_stimulus.txt
# Columns: kind, then hex fields. M rom_addr byte | W host_addr byte | R host_addr expected
# P ron ran | G waits for gsu_active to fall. ROM addresses are after cartridge mapping
# Register window, R3 and R13 bytes
W 003006 a5
W 003007 3c
W 00301a 11
W 00301b 22
R 003006 a5
R 003007 3c
R 00301a 11
R 00301b 22
# PBR, VCR and an unmapped offset
W 003034 5a
R 003034 5a
R 00303b 04
R 003032 ff
W 00303a 18
P 1 1
W 003034 00
# Host-loaded line 0x10: IWT R0 1234, ALT2, ADD #5, STOP
W 003100 f0
W 003101 34
W 003102 12
W 003103 3e
W 003104 55
W 003105 00
W 00310f 01
W 00301e 00
W 00301f 01
G
R 003000 39
R 003001 12
R 003030 00
# Bank 00 offset 8000 maps to ROM 000000: IWT R0 ABCD, ALT2, ADD #7, STOP
M 000000 f0
M 000001 cd
M 000002 ab
M 000003 3e
M 000004 57
M 000005 00
W 00301e 00
W 00301f 80
G
R 003000 d4
R 003001 ab
R 003030 08
# Line at 8010: FFFF+1, then ALT1 ADC at 8018, then 7FFF+1 at 801B
M 000010 f0
M 000011 ff
M 000012 ff
M 000013 f1
M 000014 01
M 000015 00
M 000016 51
M 000017 00
M 000018 3d
M 000019 51
M 00001a 00
M 00001b f0
M 00001c ff
M 00001d 7f
M 00001e 51
M 00001f 00
W 00301e 10
W 00301f 80
G
R 003000 00
R 003001 00
R 003030 06
W 00301e 18
W 00301f 80
G
R 003000 02
R 003030 00
W 00301e 1b
W 00301f 80
G
R 003000 00
R 003001 80
R 003030 18
# Write to R3 during a fill at 8020 is dropped
M 000020 01
W 00301e 20
W 00301f 80
W 003006 77
G
R 003006 a5

//--- bench/gsu_tb.sv
`default_nettype none

module gsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Idle cycles after each host write strobe
  localparam int WR_GAP = 2;
  // Cycle budget for each stimulus line
  localparam int CYCLES_PER_LINE = 300;

  logic        clkin;
  logic        arst_n;
  logic        cs;
  logic        reg_we_rising;
  logic [23:0] addr;
  logic [7:0]  di;
  logic [7:0]  rom_di;
  logic        rom_rdy;
  logic [7:0]  dout;
  logic [23:0] rom_addr;
  logic        rom_rrq;
  logic        gsu_active;
  logic        ron;
  logic        ran;

  // ROM image, keyed by mapped ROM address
  logic [7:0]  rom_mem [bit [23:0]];

  // Host commands in file order
  logic [7:0]  cmd_kind [$];
  logic [23:0] cmd_addr [$];
  logic [15:0] cmd_data [$];

  logic [31:0] rng_state;
  int          cycles = 0;
  int          cycle_limit = 0;

  gsu_top #(
    .VCR_VALUE(8'h04)
  ) i_dut (
    .clkin        (clkin),
    .arst_n       (arst_n),
    .cs           (cs),
    .reg_we_rising(reg_we_rising),
    .addr         (addr),
    .di           (di),
    .rom_di       (rom_di),
    .rom_rdy      (rom_rdy),
    .dout         (dout),
    .rom_addr     (rom_addr),
    .rom_rrq      (rom_rrq),
    .gsu_active   (gsu_active),
    .ron          (ron),
    .ran          (ran)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s gave %04h, expected %04h",
               $time, what, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One-cycle strobe, then room for the cache write sequencer
  task automatic host_write(input logic [23:0] a, input logic [7:0] d);
    @(posedge clkin);
    cs            <= 1'b1;
    addr          <= a;
    di            <= d;
    reg_we_rising <= 1'b1;
    @(posedge clkin);
    cs            <= 1'b0;
    reg_we_rising <= 1'b0;
    repeat (WR_GAP) @(posedge clkin);
  endtask

  // Data out is registered one cycle after the address
  task automatic host_read(input logic [23:0] a, output logic [7:0] value);
    @(posedge clkin);
    cs            <= 1'b1;
    addr          <= a;
    reg_we_rising <= 1'b0;
    @(posedge clkin);
    cs <= 1'b0;
    @(negedge clkin);
    value = dout;
  endtask

  // End of program
  task automatic wait_idle();
    @(negedge clkin);
    // Program was just started by the host
    check_equal({15'd0, gsu_active}, 16'd1, "gsu_active after program start");
    while (gsu_active === 1'b1) begin
      @(negedge clkin);
    end
  endtask

  ////////////////////
  // Clock and timeout
  ////////////////////

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  always @(posedge clkin) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("Run did not finish within %0d clock cycles", cycle_limit));
    end
  end

  ////////////////////
  // ROM model
  ////////////////////

  // Answers each request after 1 to 4 cycles
  initial begin
    logic [23:0] req_addr;
    int          delay;
    rom_rdy   = 1'b0;
    rom_di    = 8'h00;
    rng_state = 32'd43;
    forever begin
      @(negedge clkin);
      if (rom_rrq === 1'b1) begin
        req_addr  = rom_addr;
        rng_state = xorshift32(rng_state);
        delay     = 1 + int'(rng_state[1:0]);
        repeat (delay) @(posedge clkin);
        rom_rdy <= 1'b1;
        // Unlisted bytes read as STOP
        if (rom_mem.exists(req_addr)) begin
          rom_di <= rom_mem[req_addr];
        end else begin
          rom_di <= 8'h00;
        end
        @(posedge clkin);
        rom_rdy <= 1'b0;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int          fd;
    int          line_count;
    int          fields;
    string       line;
    logic [7:0]  kind;
    logic [31:0] val_a;
    logic [31:0] val_b;
    logic [7:0]  rd_val;
    arst_n        = 1'b0;
    cs            = 1'b0;
    reg_we_rising = 1'b0;
    addr          = '0;
    di            = '0;
    line_count    = 0;

    fd = $fopen("bench/gsu_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Stimulus file bench/gsu_stimulus.txt could not be opened");
    end else begin
      // Comment and blank lines skipped
      while ($fgets(line, fd) != 0) begin
        kind = line.getc(0);
        if (kind != "#" && kind != "\n") begin
          line_count++;
          val_a  = '0;
          val_b  = '0;
          fields = 0;
          if (line.len() > 1) begin
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", val_a, val_b);
          end
          // Every kind but G carries two fields
          if (kind != "G" && fields != 2) begin
            abort_run($sformatf("Malformed line in stimulus file: %s", line));
          end
          case (kind)
            "M": rom_mem[val_a[23:0]] = val_b[7:0];
            "W", "R", "P", "G": begin
              cmd_kind.push_back(kind);
              cmd_addr.push_back(val_a[23:0]);
              cmd_data.push_back(val_b[15:0]);
            end
            default: abort_run($sformatf("Unknown line in stimulus file: %s", line));
          endcase
        end
      end
      $fclose(fd);
    end
    cycle_limit = CYCLES_PER_LINE * line_count;

    // Reset over four rising edges
    repeat (4) @(posedge clkin);
    arst_n <= 1'b1;

    for (int i = 0; i < cmd_kind.size(); i++) begin
      case (cmd_kind[i])
        "W": host_write(cmd_addr[i], cmd_data[i][7:0]);
        "R": begin
          host_read(cmd_addr[i], rd_val);
          check_equal({8'h00, rd_val}, {8'h00, cmd_data[i][7:0]},
                      $sformatf("Host read at %06h", cmd_addr[i]));
        end
        "P": begin
          @(negedge clkin);
          check_equal({14'd0, ron, ran}, {14'd0, cmd_addr[i][0], cmd_data[i][0]},
                      "ron and ran");
        end
        default: wait_idle();
      endcase
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/gsu_cache.sv
`default_nettype none

module gsu_cache (
  input  wire                      clkin,
  input  wire                      arst_n,
  input  wire gsu_pkg::cache_wr_t  host_wr,
  input  wire gsu_pkg::cache_wr_t  fill_wr,
  input  wire                      fill_busy,
  input  wire gsu_pkg::cache_idx_t pc_idx,
  output gsu_pkg::byte_t           op_byte,
  output logic                     line_valid,
  output logic                     host_busy
);
  import gsu_pkg::*;

  byte_t         mem [512];
  logic [31:0]   flags;
  hostwr_state_t hw_state;
  cache_idx_t    held_idx;
  byte_t         held_data;
  cache_wr_t     port;

  ////////////////////
  // Host write sequencer
  ////////////////////

  assign host_busy = hw_state != hw_idle;

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      hw_state <= hw_idle;
    end else begin
      case (hw_state)
        // Dropped while a line fill runs
        hw_idle: begin
          if (host_wr.en && !fill_busy) begin
            hw_state <= hw_hold;
          end
        end
        hw_hold:  hw_state <= hw_write;
        // Wait out a fill byte on the port
        hw_write: begin
          if (!fill_wr.en) begin
            hw_state <= hw_idle;
          end
        end
        default:  hw_state <= hw_idle;
      endcase
    end
  end

  always_ff @(posedge clkin) begin
    if (hw_state == hw_idle && host_wr.en) begin
      held_idx  <= host_wr.idx;
      held_data <= host_wr.data;
    end
  end

  ////////////////////
  // Write port
  ////////////////////

  // Fill first, then the held host byte
  always_comb begin
    port = fill_wr;
    if (!fill_wr.en) begin
      port.en   = hw_state == hw_write;
      port.idx  = held_idx;
      port.data = held_data;
    end
  end

  always_ff @(posedge clkin) begin
    if (port.en) begin
      mem[port.idx] <= port.data;
    end
  end

  // Last byte of a line marks it valid
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (port.en && &port.idx[3:0]) begin
      flags[port.idx[8:4]] <= 1'b1;
    end
  end

  assign op_byte    = mem[pc_idx];
  assign line_valid = flags[pc_idx[8:4]];

endmodule

`default_nettype wire

//--- hdl/gsu_cache_fill.sv
`default_nettype none

module gsu_cache_fill (
  input  wire                      clkin,
  input  wire                      arst_n,
  input  wire                      fill_req,
  input  wire gsu_pkg::line_idx_t  fill_line,
  input  wire gsu_pkg::bus_addr_t  fill_base,
  input  wire                      host_busy,
  input  wire gsu_pkg::byte_t      rom_di,
  input  wire                      rom_rdy,
  output gsu_pkg::cache_wr_t       fill_wr,
  output logic                     fill_busy,
  output logic                     rom_rrq,
  output gsu_pkg::bus_addr_t       rom_addr
);
  import gsu_pkg::*;

  fill_state_t state;
  line_idx_t   line;
  bus_addr_t   src;
  logic [3:0]  count;
  byte_t       data;

  assign fill_busy = state != fs_idle;
  // Single request cycle, address held through the wait
  assign rom_rrq   = state == fs_req;
  assign rom_addr  = rom_map(src);

  // One cache byte per advance cycle
  assign fill_wr.en   = state == fs_next;
  assign fill_wr.idx  = {line, count};
  assign fill_wr.data = data;

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      state <= fs_idle;
      count <= '0;
    end else begin
      case (state)
        fs_idle: begin
          // Leave the port to a pending host write
          if (fill_req && !host_busy) begin
            state <= fs_req;
            count <= '0;
          end
        end
        fs_req:  state <= fs_wait;
        fs_wait: begin
          if (rom_rdy) begin
            state <= fs_next;
          end
        end
        fs_next: begin
          count <= count + 4'd1;
          state <= (count == 4'(LINE_BYTES - 1)) ? fs_idle : fs_req;
        end
        default: state <= fs_idle;
      endcase
    end
  end

  // Line, source address and ROM byte
  always_ff @(posedge clkin) begin
    if (state == fs_idle && fill_req && !host_busy) begin
      line <= fill_line;
      src  <= fill_base;
    end
    if (state == fs_wait && rom_rdy) begin
      data <= rom_di;
    end
    if (state == fs_next) begin
      src <= src + 24'd1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/gsu_core.sv
`default_nettype none

module gsu_core (
  input  wire                        clkin,
  input  wire                        arst_n,
  input  wire gsu_pkg::sfr_host_wr_t sfr_wr,
  input  wire gsu_pkg::byte_t        op_byte,
  input  wire                        line_valid,
  input  wire gsu_pkg::word_t        rd_a,
  input  wire gsu_pkg::word_t        rd_b,
  input  wire gsu_pkg::word_t        pc,
  input  wire gsu_pkg::byte_t        pbr,
  output gsu_pkg::gpr_core_wr_t      core_wr,
  output logic                       pc_inc,
  output gsu_pkg::reg_idx_t          rd_a_idx,
  output gsu_pkg::reg_idx_t          rd_b_idx,
  output gsu_pkg::word_t             sfr,
  output logic                       running,
  output logic                       fill_req,
  output gsu_pkg::line_idx_t         fill_line,
  output gsu_pkg::bus_addr_t         fill_base
);
  import gsu_pkg::*;

  core_state_t state;
  byte_t       op;
  byte_t       imm_lo;
  byte_t       imm_hi;
  logic        fetch;
  logic        is_adx;
  logic        is_iwt;
  word_t       operand;
  logic [16:0] sum;

  ////////////////////
  // Fetch
  ////////////////////

  // States that consume a byte at PC
  assign fetch   = state inside {st_op, st_arg_lo, st_arg_hi};
  assign pc_inc  = fetch && line_valid;
  assign running = state != st_idle;

  // Stall and ask for the line at PC
  assign fill_req  = fetch && !line_valid;
  assign fill_line = pc[8:4];
  assign fill_base = {pbr, pc[15:4], 4'h0};

  ////////////////////
  // ALU
  ////////////////////

  assign is_adx = op[7:4] == OPHI_ADX;
  assign is_iwt = op[7:4] == OPHI_IWT;

  // Source always R0; Rn or #n from the low nibble
  assign rd_a_idx = '0;
  assign rd_b_idx = op[3:0];
  assign operand  = sfr[FLAG_ALT2] ? word_t'(op[3:0]) : rd_b;
  // ALT1 selects ADC
  assign sum = {1'b0, rd_a} + {1'b0, operand} + 17'(sfr[FLAG_ALT1] & sfr[FLAG_CY]);

  // ADD to R0, IWT to Rn
  assign core_wr.en   = state == st_wb && (is_adx || is_iwt);
  assign core_wr.idx  = is_iwt ? op[3:0] : '0;
  assign core_wr.data = is_iwt ? {imm_hi, imm_lo} : sum[15:0];

  ////////////////////
  // Sequencer and SFR
  ////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      sfr   <= '0;
    end else begin
      // Host side, bits 0 and 7 stay clear
      if (sfr_wr.en_lo) begin
        sfr[7:0] <= {1'b0, sfr_wr.data[6:1], 1'b0};
      end
      if (sfr_wr.en_hi) begin
        sfr[15:8] <= {sfr_wr.data[7], 2'b00, sfr_wr.data[4:0]};
      end

      case (state)
        st_idle: begin
          if (sfr_wr.en_lo && sfr_wr.data[FLAG_G]) begin
            state <= st_op;
          end
        end
        st_op: begin
          if (line_valid) begin
            state <= (op_byte[7:4] == OPHI_IWT) ? st_arg_lo : st_wb;
          end
        end
        st_arg_lo: begin
          if (line_valid) begin
            state <= st_arg_hi;
          end
        end
        st_arg_hi: begin
          if (line_valid) begin
            state <= st_wb;
          end
        end
        st_wb: begin
          if (op == OP_ALT1) begin
            sfr[FLAG_ALT1] <= 1'b1;
            sfr[FLAG_ALT2] <= 1'b0;
          end else if (op == OP_ALT2) begin
            sfr[FLAG_ALT1] <= 1'b0;
            sfr[FLAG_ALT2] <= 1'b1;
          end else if (op == OP_ALT3) begin
            sfr[FLAG_ALT1] <= 1'b1;
            sfr[FLAG_ALT2] <= 1'b1;
          end else begin
            // Prefixes end here, NOP and unknown opcodes included
            sfr[FLAG_ALT1] <= 1'b0;
            sfr[FLAG_ALT2] <= 1'b0;
            sfr[FLAG_B]    <= 1'b0;
            if (is_adx) begin
              sfr[FLAG_Z]  <= sum[15:0] == 16'd0;
              sfr[FLAG_S]  <= sum[15];
              sfr[FLAG_CY] <= sum[16];
              // Same-sign operands, result sign flipped
              sfr[FLAG_OV] <= (rd_a[15] == operand[15]) && (sum[15] != rd_a[15]);
            end
            if (op == OP_STOP) begin
              sfr[FLAG_G] <= 1'b0;
            end
          end
          state <= (op == OP_STOP) ? st_idle : st_op;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Opcode and immediate bytes
  always_ff @(posedge clkin) begin
    if (line_valid) begin
      case (state)
        st_op:     op <= op_byte;
        st_arg_lo: imm_lo <= op_byte;
        st_arg_hi: imm_hi <= op_byte;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/gsu_mmio.sv
`default_nettype none

module gsu_mmio #(
  parameter gsu_pkg::byte_t VCR_VALUE = 8'h04
) (
  input  wire                     clkin,
  input  wire                     arst_n,
  input  wire                     cs,
  input  wire                     reg_we_rising,
  input  wire gsu_pkg::bus_addr_t addr,
  input  wire gsu_pkg::byte_t     di,
  input  wire                     running,
  input  wire gsu_pkg::word_t     host_rd_word,
  input  wire gsu_pkg::word_t     sfr,
  output gsu_pkg::byte_t          dout,
  output gsu_pkg::reg_idx_t       host_rd_idx,
  output gsu_pkg::gpr_host_wr_t   gpr_wr,
  output gsu_pkg::sfr_host_wr_t   sfr_wr,
  output gsu_pkg::cache_wr_t      host_cache_wr,
  output gsu_pkg::byte_t          pbr,
  output logic [5:0]              scmr
);
  import gsu_pkg::*;

  mmio_off_t off;
  logic      win_sel;
  logic      reg_sel;
  logic      cache_sel;
  logic      reg_wr;
  logic      r15_hi_wr;
  logic      bramr;
  byte_t     cfgr;
  byte_t     scbr;
  logic      clsr;
  byte_t     rd_byte;

  ////////////////////
  // Decode
  ////////////////////

  // Banks with bit 22 clear, page 3xxx
  assign off       = addr[9:0];
  assign win_sel   = cs && !addr[22] && addr[15:12] == 4'h3;
  assign reg_sel   = win_sel && addr[11:6] == 6'd0;
  // 3100-32FF
  assign cache_sel = win_sel && addr[11:10] == 2'b00 && (addr[9] ^ addr[8]);
  // Register writes only while the core is stopped
  assign reg_wr    = reg_sel && reg_we_rising && !running;

  // R0-R15 at 000-01F, low byte first
  assign gpr_wr.en   = reg_wr && !off[5];
  assign gpr_wr.idx  = off[4:1];
  assign gpr_wr.hi   = off[0];
  assign gpr_wr.data = di;

  // High byte of R15 also sets G
  assign r15_hi_wr = gpr_wr.en && gpr_wr.hi && gpr_wr.idx == PC_IDX;

  assign sfr_wr.en_lo = (reg_wr && off == OFF_SFR_LO) || r15_hi_wr;
  assign sfr_wr.en_hi = reg_wr && off == OFF_SFR_HI;
  assign sfr_wr.data  = r15_hi_wr ? (sfr[7:0] | byte_t'(1 << FLAG_G)) : di;

  // Cache index straight from the address
  assign host_cache_wr.en   = cache_sel && reg_we_rising;
  assign host_cache_wr.idx  = addr[8:0];
  assign host_cache_wr.data = di;

  ////////////////////
  // Control registers
  ////////////////////

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      bramr <= 1'b0;
      pbr   <= '0;
      cfgr  <= '0;
      scbr  <= '0;
      clsr  <= 1'b0;
      scmr  <= '0;
    end else if (reg_wr) begin
      case (off)
        OFF_BRAMR: bramr <= di[0];
        OFF_PBR:   pbr <= di;
        // Only IRQ mask and multiplier speed bits
        OFF_CFGR:  cfgr <= {di[7], 1'b0, di[5], 5'b00000};
        OFF_SCBR:  scbr <= di;
        OFF_CLSR:  clsr <= di[0];
        OFF_SCMR:  scmr <= di[5:0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  assign host_rd_idx = off[4:1];

  always_comb begin
    rd_byte = 8'hFF;
    if (!off[5]) begin
      rd_byte = off[0] ? host_rd_word[15:8] : host_rd_word[7:0];
    end else begin
      case (off)
        OFF_SFR_LO: rd_byte = sfr[7:0];
        OFF_SFR_HI: rd_byte = sfr[15:8];
        OFF_BRAMR:  rd_byte = {7'd0, bramr};
        OFF_PBR:    rd_byte = pbr;
        // No bank switching, both banks stay at 0
        OFF_ROMBR:  rd_byte = 8'h00;
        OFF_CFGR:   rd_byte = cfgr;
        OFF_SCBR:   rd_byte = scbr;
        OFF_CLSR:   rd_byte = {7'd0, clsr};
        OFF_SCMR:   rd_byte = {2'b00, scmr};
        OFF_VCR:    rd_byte = VCR_VALUE;
        OFF_RAMBR:  rd_byte = 8'h00;
        default:    rd_byte = 8'hFF;
      endcase
    end
  end

  // One cycle after address; cache window reads FF
  always_ff @(posedge clkin) begin
    dout <= reg_sel ? rd_byte : 8'hFF;
  end

endmodule

`default_nettype wire

//--- hdl/gsu_pkg.sv
`default_nettype none

package gsu_pkg;

  ////////////////////
  // Widths
  ////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [8:0]  cache_idx_t;
  typedef logic [4:0]  line_idx_t;
  typedef logic [23:0] bus_addr_t;
  typedef logic [9:0]  mmio_off_t;

  // Program counter and ROM address pointer
  localparam reg_idx_t PC_IDX  = 4'd15;
  localparam reg_idx_t RAP_IDX = 4'd14;

  // SFR bit positions
  localparam int FLAG_Z    = 1;
  localparam int FLAG_CY   = 2;
  localparam int FLAG_S    = 3;
  localparam int FLAG_OV   = 4;
  localparam int FLAG_G    = 5;
  localparam int FLAG_R    = 6;
  localparam int FLAG_ALT1 = 8;
  localparam int FLAG_ALT2 = 9;
  localparam int FLAG_IL   = 10;
  localparam int FLAG_IH   = 11;
  localparam int FLAG_B    = 12;
  localparam int FLAG_IRQ  = 15;

  ////////////////////
  // Host window
  ////////////////////

  // Offsets past the register file
  localparam mmio_off_t OFF_SFR_LO = 10'h030;
  localparam mmio_off_t OFF_SFR_HI = 10'h031;
  localparam mmio_off_t OFF_BRAMR  = 10'h033;
  localparam mmio_off_t OFF_PBR    = 10'h034;
  localparam mmio_off_t OFF_ROMBR  = 10'h036;
  localparam mmio_off_t OFF_CFGR   = 10'h037;
  localparam mmio_off_t OFF_SCBR   = 10'h038;
  localparam mmio_off_t OFF_CLSR   = 10'h039;
  localparam mmio_off_t OFF_SCMR   = 10'h03A;
  localparam mmio_off_t OFF_VCR    = 10'h03B;
  localparam mmio_off_t OFF_RAMBR  = 10'h03C;

  ////////////////////
  // Instruction set
  ////////////////////

  localparam byte_t OP_STOP = 8'h00;
  localparam byte_t OP_NOP  = 8'h01;
  localparam byte_t OP_ALT1 = 8'h3D;
  localparam byte_t OP_ALT2 = 8'h3E;
  localparam byte_t OP_ALT3 = 8'h3F;

  // Opcode groups with a register number in the low nibble
  localparam logic [3:0] OPHI_ADX = 4'h5;
  localparam logic [3:0] OPHI_IWT = 4'hF;

  localparam int LINE_BYTES = 16;

  typedef enum logic [2:0] {st_idle, st_op, st_arg_lo, st_arg_hi, st_wb} core_state_t;
  typedef enum logic [1:0] {fs_idle, fs_req, fs_wait, fs_next} fill_state_t;
  typedef enum logic [1:0] {hw_idle, hw_hold, hw_write} hostwr_state_t;

  // Host byte write into one half of a register
  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    logic     hi;
    byte_t    data;
  } gpr_host_wr_t;

  typedef struct packed {
    logic  en_lo;
    logic  en_hi;
    byte_t data;
  } sfr_host_wr_t;

  // Whole word from the core
  typedef struct packed {
    logic     en;
    reg_idx_t idx;
    word_t    data;
  } gpr_core_wr_t;

  typedef struct packed {
    logic       en;
    cache_idx_t idx;
    byte_t      data;
  } cache_wr_t;

  // Cartridge ROM mapping
  function automatic bus_addr_t rom_map(input bus_addr_t addr);
    // Banks 00-3F, upper half of each bank
    if (addr[23:22] == 2'b00 && addr[15]) begin
      return {3'b000, addr[21:16], addr[14:0]};
    end
    // Linear banks
    return {3'b000, addr[20:0]};
  endfunction

endpackage

`default_nettype wire

//--- hdl/gsu_regfile.sv
`default_nettype none

module gsu_regfile (
  input  wire                       clkin,
  input  wire                       arst_n,
  input  wire gsu_pkg::gpr_host_wr_t host_wr,
  input  wire gsu_pkg::gpr_core_wr_t core_wr,
  input  wire                       pc_inc,
  input  wire gsu_pkg::reg_idx_t    rd_a_idx,
  input  wire gsu_pkg::reg_idx_t    rd_b_idx,
  input  wire gsu_pkg::reg_idx_t    host_rd_idx,
  output gsu_pkg::word_t            rd_a,
  output gsu_pkg::word_t            rd_b,
  output gsu_pkg::word_t            pc,
  output gsu_pkg::word_t            host_rd
);
  import gsu_pkg::*;

  word_t regs [16];
  logic  pc_step;

  // A core write to R15 takes the place of the increment
  assign pc_step = pc_inc && !(core_wr.en && core_wr.idx == PC_IDX);

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Host and core never write in the same cycle
      if (host_wr.en) begin
        if (host_wr.hi) begin
          regs[host_wr.idx][15:8] <= host_wr.data;
        end else begin
          regs[host_wr.idx][7:0] <= host_wr.data;
        end
      end
      if (core_wr.en) begin
        regs[core_wr.idx] <= core_wr.data;
      end
      if (pc_step) begin
        regs[PC_IDX] <= regs[PC_IDX] + 16'd1;
      end
    end
  end

  // Asynchronous read ports
  assign rd_a    = regs[rd_a_idx];
  assign rd_b    = regs[rd_b_idx];
  assign pc      = regs[PC_IDX];
  assign host_rd = regs[host_rd_idx];

endmodule

`default_nettype wire

//--- hdl/gsu_top.sv
`default_nettype none

module gsu_top #(
  parameter gsu_pkg::byte_t VCR_VALUE = 8'h04
) (
  input  wire                     clkin,
  input  wire                     arst_n,
  input  wire                     cs,
  input  wire                     reg_we_rising,
  input  wire gsu_pkg::bus_addr_t addr,
  input  wire gsu_pkg::byte_t     di,
  input  wire gsu_pkg::byte_t     rom_di,
  input  wire                     rom_rdy,
  output gsu_pkg::byte_t          dout,
  output gsu_pkg::bus_addr_t      rom_addr,
  output logic                    rom_rrq,
  output logic                    gsu_active,
  output logic                    ron,
  output logic                    ran
);
  import gsu_pkg::*;

  // Host side
  gpr_host_wr_t gpr_wr;
  sfr_host_wr_t sfr_wr;
  cache_wr_t    host_cache_wr;
  reg_idx_t     host_rd_idx;
  word_t        host_rd_word;
  byte_t        pbr;
  logic [5:0]   scmr;

  // Core side
  gpr_core_wr_t core_wr;
  logic         pc_inc;
  reg_idx_t     rd_a_idx;
  reg_idx_t     rd_b_idx;
  word_t        rd_a;
  word_t        rd_b;
  word_t        pc;
  word_t        sfr;
  logic         running;
  byte_t        op_byte;
  logic         line_valid;

  // Fill side
  logic         fill_req;
  line_idx_t    fill_line;
  bus_addr_t    fill_base;
  cache_wr_t    fill_wr;
  logic         fill_busy;
  logic         host_busy;

  gsu_mmio #(
    .VCR_VALUE(VCR_VALUE)
  ) u_mmio (
    .clkin        (clkin),
    .arst_n       (arst_n),
    .cs           (cs),
    .reg_we_rising(reg_we_rising),
    .addr         (addr),
    .di           (di),
    .running      (running),
    .host_rd_word (host_rd_word),
    .sfr          (sfr),
    .dout         (dout),
    .host_rd_idx  (host_rd_idx),
    .gpr_wr       (gpr_wr),
    .sfr_wr       (sfr_wr),
    .host_cache_wr(host_cache_wr),
    .pbr          (pbr),
    .scmr         (scmr)
  );

  gsu_regfile u_regfile (
    .clkin      (clkin),
    .arst_n     (arst_n),
    .host_wr    (gpr_wr),
    .core_wr    (core_wr),
    .pc_inc     (pc_inc),
    .rd_a_idx   (rd_a_idx),
    .rd_b_idx   (rd_b_idx),
    .host_rd_idx(host_rd_idx),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .pc         (pc),
    .host_rd    (host_rd_word)
  );

  gsu_core u_core (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .sfr_wr    (sfr_wr),
    .op_byte   (op_byte),
    .line_valid(line_valid),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .pc        (pc),
    .pbr       (pbr),
    .core_wr   (core_wr),
    .pc_inc    (pc_inc),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .sfr       (sfr),
    .running   (running),
    .fill_req  (fill_req),
    .fill_line (fill_line),
    .fill_base (fill_base)
  );

  // Cache index is the low 9 bits of PC
  gsu_cache u_cache (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .host_wr   (host_cache_wr),
    .fill_wr   (fill_wr),
    .fill_busy (fill_busy),
    .pc_idx    (pc[8:0]),
    .op_byte   (op_byte),
    .line_valid(line_valid),
    .host_busy (host_busy)
  );

  gsu_cache_fill u_cache_fill (
    .clkin    (clkin),
    .arst_n   (arst_n),
    .fill_req (fill_req),
    .fill_line(fill_line),
    .fill_base(fill_base),
    .host_busy(host_busy),
    .rom_di   (rom_di),
    .rom_rdy  (rom_rdy),
    .fill_wr  (fill_wr),
    .fill_busy(fill_busy),
    .rom_rrq  (rom_rrq),
    .rom_addr (rom_addr)
  );

  // Busy while running or while either cache sequencer is working
  assign gsu_active = sfr[FLAG_G] | fill_busy | host_busy;

  // ROM and RAM bus ownership flags from SCMR
  assign ron = scmr[4];
  assign ran = scmr[3];

endmodule

`default_nettype wire

//--- sources.f
hdl/gsu_pkg.sv
hdl/gsu_mmio.sv
hdl/gsu_regfile.sv
hdl/gsu_core.sv
hdl/gsu_cache.sv
hdl/gsu_cache_fill.sv
hdl/gsu_top.sv
bench/gsu_tb.sv
